//--- build.f
+incdir+.
rv_isa_pkg.sv
ctrl_pkg.sv
inst_latch.sv
reg_file.sv
imm_gen.sv
ctrl_decode.sv
hazard_detect.sv
operand_stage.sv
id_stage.sv
tb_clock.sv
id_stage_tb.sv

//--- ctrl_decode.sv
module ctrl_decode
    import rv_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  rv_inst_u             inst,
    output logic [alu_fn_w-1:0]  exe_fun,
    output logic [sel_w-1:0]     op1_sel,
    output logic [sel_w-1:0]     op2_sel,
    output logic [mem_op_w-1:0]  mem_op,
    output logic                 rf_wen,
    output logic [wb_sel_w-1:0]  wb_sel,
    output logic                 jmp_flg
);

    // {exe_fun, op1_sel, op2_sel, mem_op, rf_wen, wb_sel}
    logic [alu_fn_w+2*sel_w+mem_op_w+wb_sel_w:0] row;

    always_comb begin
        row = {alu_add, op1_none, op2_none, mem_none, 1'b0, wb_none};   // unknown word
        case (inst.r.opcode)
            op_load: begin
                case (inst.i.funct3)
                    f3_lb:  row = {alu_add, op1_rs1, op2_imi, mem_lb, 1'b1, wb_memb};
                    f3_lbu: row = {alu_add, op1_rs1, op2_imi, mem_lbu, 1'b1, wb_membu};
                    f3_lh:  row = {alu_add, op1_rs1, op2_imi, mem_lh, 1'b1, wb_memh};
                    f3_lhu: row = {alu_add, op1_rs1, op2_imi, mem_lhu, 1'b1, wb_memhu};
                    f3_lw:  row = {alu_add, op1_rs1, op2_imi, mem_lw, 1'b1, wb_memw};
                    default: ;
                endcase
            end
            op_store: begin
                case (inst.s.funct3)
                    f3_sb: row = {alu_add, op1_rs1, op2_ims, mem_sb, 1'b0, wb_none};
                    f3_sh: row = {alu_add, op1_rs1, op2_ims, mem_sh, 1'b0, wb_none};
                    f3_sw: row = {alu_add, op1_rs1, op2_ims, mem_sw, 1'b0, wb_none};
                    default: ;
                endcase
            end
            op_op: begin
                case ({inst.r.funct7, inst.r.funct3})
                    {7'd0, f3_add}:       row = {alu_add, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {funct7_alt, f3_add}: row = {alu_sub, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_and}:       row = {alu_and, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_or}:        row = {alu_or, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_xor}:       row = {alu_xor, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_sll}:       row = {alu_sll, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_srl}:       row = {alu_srl, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {funct7_alt, f3_srl}: row = {alu_sra, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_slt}:       row = {alu_slt, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    {7'd0, f3_sltu}:      row = {alu_sltu, op1_rs1, op2_rs2, mem_none, 1'b1, wb_alu};
                    default: ;
                endcase
            end
            op_op_imm: begin
                case (inst.i.funct3)
                    f3_add:  row = {alu_add, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_and:  row = {alu_and, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_or:   row = {alu_or, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_xor:  row = {alu_xor, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_slt:  row = {alu_slt, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_sltu: row = {alu_sltu, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    f3_sll: begin
                        if (inst.r.funct7 == 7'd0)
                            row = {alu_sll, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    end
                    f3_srl: begin   // shamt sits in rs2, funct7 picks srli or srai
                        if (inst.r.funct7 == 7'd0)
                            row = {alu_srl, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                        else if (inst.r.funct7 == funct7_alt)
                            row = {alu_sra, op1_rs1, op2_imi, mem_none, 1'b1, wb_alu};
                    end
                    default: ;
                endcase
            end
            op_branch: begin
                case (inst.b.funct3)
                    f3_beq:  row = {br_beq, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    f3_bne:  row = {br_bne, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    f3_blt:  row = {br_blt, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    f3_bge:  row = {br_bge, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    f3_bltu: row = {br_bltu, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    f3_bgeu: row = {br_bgeu, op1_rs1, op2_imb, mem_none, 1'b0, wb_none};
                    default: ;
                endcase
            end
            op_jal:   row = {alu_add, op1_pc, op2_imj, mem_none, 1'b1, wb_pc};
            op_jalr: begin
                if (inst.i.funct3 == f3_jalr)
                    row = {alu_jalr, op1_rs1, op2_imi, mem_none, 1'b1, wb_pc};
            end
            op_lui:   row = {alu_add, op1_none, op2_imu, mem_none, 1'b1, wb_alu};
            op_auipc: row = {alu_add, op1_pc, op2_imu, mem_none, 1'b1, wb_alu};
            default: ;
        endcase
    end

    assign {exe_fun, op1_sel, op2_sel, mem_op, rf_wen, wb_sel} = row;

    assign jmp_flg = (inst.j.opcode == op_jal) ||
                     (inst.i.opcode == op_jalr && inst.i.funct3 == f3_jalr);

endmodule

//--- ctrl_pkg.sv
package ctrl_pkg;

    localparam int alu_fn_w = 5;

    localparam logic [alu_fn_w-1:0] alu_add  = 5'd0;
    localparam logic [alu_fn_w-1:0] alu_sub  = 5'd1;
    localparam logic [alu_fn_w-1:0] alu_and  = 5'd2;
    localparam logic [alu_fn_w-1:0] alu_or   = 5'd3;
    localparam logic [alu_fn_w-1:0] alu_xor  = 5'd4;
    localparam logic [alu_fn_w-1:0] alu_sll  = 5'd5;
    localparam logic [alu_fn_w-1:0] alu_srl  = 5'd6;
    localparam logic [alu_fn_w-1:0] alu_sra  = 5'd7;
    localparam logic [alu_fn_w-1:0] alu_slt  = 5'd8;
    localparam logic [alu_fn_w-1:0] alu_sltu = 5'd9;
    localparam logic [alu_fn_w-1:0] alu_jalr = 5'd10;
    // branch compares, evaluated in execute
    localparam logic [alu_fn_w-1:0] br_beq   = 5'd11;
    localparam logic [alu_fn_w-1:0] br_bne   = 5'd12;
    localparam logic [alu_fn_w-1:0] br_blt   = 5'd13;
    localparam logic [alu_fn_w-1:0] br_bge   = 5'd14;
    localparam logic [alu_fn_w-1:0] br_bltu  = 5'd15;
    localparam logic [alu_fn_w-1:0] br_bgeu  = 5'd16;

    localparam int sel_w = 4;

    localparam logic [sel_w-1:0] op1_rs1  = 4'd0;
    localparam logic [sel_w-1:0] op1_pc   = 4'd1;
    localparam logic [sel_w-1:0] op1_none = 4'd2;

    localparam logic [sel_w-1:0] op2_rs2  = 4'd0;
    localparam logic [sel_w-1:0] op2_imi  = 4'd1;
    localparam logic [sel_w-1:0] op2_ims  = 4'd2;
    localparam logic [sel_w-1:0] op2_imb  = 4'd3;   // branch target offset
    localparam logic [sel_w-1:0] op2_imj  = 4'd4;
    localparam logic [sel_w-1:0] op2_imu  = 4'd5;
    localparam logic [sel_w-1:0] op2_none = 4'd6;

    localparam int mem_op_w = 4;

    localparam logic [mem_op_w-1:0] mem_none = 4'd0;
    localparam logic [mem_op_w-1:0] mem_lb   = 4'd1;
    localparam logic [mem_op_w-1:0] mem_lbu  = 4'd2;
    localparam logic [mem_op_w-1:0] mem_lh   = 4'd3;
    localparam logic [mem_op_w-1:0] mem_lhu  = 4'd4;
    localparam logic [mem_op_w-1:0] mem_lw   = 4'd5;
    localparam logic [mem_op_w-1:0] mem_sb   = 4'd6;
    localparam logic [mem_op_w-1:0] mem_sh   = 4'd7;
    localparam logic [mem_op_w-1:0] mem_sw   = 4'd8;

    localparam int wb_sel_w = 4;

    localparam logic [wb_sel_w-1:0] wb_none  = 4'd0;
    localparam logic [wb_sel_w-1:0] wb_alu   = 4'd1;
    localparam logic [wb_sel_w-1:0] wb_pc    = 4'd2;   // link address
    localparam logic [wb_sel_w-1:0] wb_memb  = 4'd3;
    localparam logic [wb_sel_w-1:0] wb_membu = 4'd4;
    localparam logic [wb_sel_w-1:0] wb_memh  = 4'd5;
    localparam logic [wb_sel_w-1:0] wb_memhu = 4'd6;
    localparam logic [wb_sel_w-1:0] wb_memw  = 4'd7;

endpackage

//--- hazard_detect.sv
module hazard_detect
    import rv_isa_pkg::*;
(
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  exe_rf_wen,
    input  logic [reg_addr_w-1:0] exe_wb_addr,
    input  logic                  mem_rf_wen,
    input  logic [reg_addr_w-1:0] mem_wb_addr,
    input  logic                  wb_rf_wen,
    input  logic [reg_addr_w-1:0] wb_wb_addr,
    output logic                  hazard_stall
);

    // source register still waiting on a write further down the pipe
    function automatic logic pending(input logic [reg_addr_w-1:0] addr);
        pending = (addr != '0) &&
                  ((exe_rf_wen && exe_wb_addr == addr) ||
                   (mem_rf_wen && mem_wb_addr == addr) ||
                   (wb_rf_wen  && wb_wb_addr  == addr));
    endfunction

    always_comb begin
        hazard_stall = pending(rs1_addr) || pending(rs2_addr);
    end

endmodule

//--- id_stage.sv
module id_stage
    import rv_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       in_inst,
    input  logic [xlen-1:0]       in_pc,
    input  logic                  mem_stall,
    input  logic                  flush,
    input  logic                  exe_rf_wen,
    input  logic [reg_addr_w-1:0] exe_wb_addr,
    input  logic                  mem_rf_wen,
    input  logic [reg_addr_w-1:0] mem_wb_addr,
    input  logic                  wb_rf_wen,
    input  logic [reg_addr_w-1:0] wb_wb_addr,
    input  logic                  rf_we,
    input  logic [reg_addr_w-1:0] rf_waddr,
    input  logic [xlen-1:0]       rf_wdata,
    output logic [xlen-1:0]       out_pc,
    output logic [alu_fn_w-1:0]   exe_fun,
    output logic [xlen-1:0]       op1_data,
    output logic [xlen-1:0]       op2_data,
    output logic [xlen-1:0]       rs2_data,
    output logic [mem_op_w-1:0]   mem_op,
    output logic                  rf_wen,
    output logic [wb_sel_w-1:0]   wb_sel,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic                  jmp_flg,
    output logic                  hazard_stall
);

    rv_inst_u              id_inst;
    logic [xlen-1:0]       id_pc;
    logic [xlen-1:0]       rf_rs1_data;
    logic [xlen-1:0]       rf_rs2_data;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_s;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_j;
    logic [xlen-1:0]       imm_u;
    logic [alu_fn_w-1:0]   dec_exe_fun;
    logic [sel_w-1:0]      op1_sel;
    logic [sel_w-1:0]      op2_sel;
    logic [mem_op_w-1:0]   dec_mem_op;
    logic                  dec_rf_wen;
    logic [wb_sel_w-1:0]   dec_wb_sel;
    logic                  dec_jmp_flg;

    inst_latch inst_latch_i (
        .clk          (clk),
        .reset        (reset),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .mem_stall    (mem_stall),
        .hazard_stall (hazard_stall),
        .flush        (flush),
        .id_inst      (id_inst),
        .id_pc        (id_pc)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (id_inst.r.rs1),
        .rs2_addr (id_inst.r.rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    imm_gen imm_gen_i (
        .inst  (id_inst),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_j (imm_j),
        .imm_u (imm_u)
    );

    ctrl_decode ctrl_decode_i (
        .inst    (id_inst),
        .exe_fun (dec_exe_fun),
        .op1_sel (op1_sel),
        .op2_sel (op2_sel),
        .mem_op  (dec_mem_op),
        .rf_wen  (dec_rf_wen),
        .wb_sel  (dec_wb_sel),
        .jmp_flg (dec_jmp_flg)
    );

    hazard_detect hazard_detect_i (
        .rs1_addr     (id_inst.r.rs1),
        .rs2_addr     (id_inst.r.rs2),
        .exe_rf_wen   (exe_rf_wen),
        .exe_wb_addr  (exe_wb_addr),
        .mem_rf_wen   (mem_rf_wen),
        .mem_wb_addr  (mem_wb_addr),
        .wb_rf_wen    (wb_rf_wen),
        .wb_wb_addr   (wb_wb_addr),
        .hazard_stall (hazard_stall)
    );

    operand_stage operand_stage_i (
        .clk          (clk),
        .reset        (reset),
        .id_pc        (id_pc),
        .id_inst      (id_inst),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .imm_i        (imm_i),
        .imm_s        (imm_s),
        .imm_b        (imm_b),
        .imm_j        (imm_j),
        .imm_u        (imm_u),
        .dec_exe_fun  (dec_exe_fun),
        .op1_sel      (op1_sel),
        .op2_sel      (op2_sel),
        .dec_mem_op   (dec_mem_op),
        .dec_rf_wen   (dec_rf_wen),
        .dec_wb_sel   (dec_wb_sel),
        .dec_jmp_flg  (dec_jmp_flg),
        .mem_stall    (mem_stall),
        .hazard_stall (hazard_stall),
        .out_pc       (out_pc),
        .exe_fun      (exe_fun),
        .op1_data     (op1_data),
        .op2_data     (op2_data),
        .rs2_data     (rs2_data),
        .mem_op       (mem_op),
        .rf_wen       (rf_wen),
        .wb_sel       (wb_sel),
        .wb_addr      (wb_addr),
        .jmp_flg      (jmp_flg)
    );

endmodule

//--- id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  exe_fun;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] rs2;
    logic [3:0]  mem_op;
    logic        rf_wen;
    logic [3:0]  wb_sel;
    logic [4:0]  wb_addr;
    logic        jmp;
} exp_t;

function automatic exp_t bubble_exp();
    exp_t e;
    e = '0;
    e.pc      = pc_nop;
    e.exe_fun = alu_add;
    e.mem_op  = mem_none;
    e.wb_sel  = wb_none;
    return e;
endfunction

// expected execute outputs for one held word
function automatic exp_t decode_ref(input logic [31:0] w, input logic [31:0] pc,
                                    input logic [31:0] regs [0:31]);
    exp_t e;
    logic [31:0] rs1v;
    logic [31:0] im_i;
    logic [31:0] im_s;
    logic [31:0] im_b;
    logic [31:0] im_j;
    logic [31:0] im_u;
    logic [2:0]  f3;
    logic [6:0]  f7;
    e = bubble_exp();
    rs1v = regs[w[19:15]];
    im_i = {{20{w[31]}}, w[31:20]};
    im_s = {{20{w[31]}}, w[31:25], w[11:7]};
    im_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    im_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    im_u = {w[31:12], 12'd0};
    f3 = w[14:12];
    f7 = w[31:25];
    e.pc      = pc;
    e.rs2     = regs[w[24:20]];
    e.wb_addr = w[11:7];
    case (w[6:0])
        op_load: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
            e.op1 = rs1v;
            e.op2 = im_i;
            e.rf_wen = 1'b1;
            case (f3)
                3'd0: begin e.mem_op = mem_lb;  e.wb_sel = wb_memb;  end
                3'd4: begin e.mem_op = mem_lbu; e.wb_sel = wb_membu; end
                3'd1: begin e.mem_op = mem_lh;  e.wb_sel = wb_memh;  end
                3'd5: begin e.mem_op = mem_lhu; e.wb_sel = wb_memhu; end
                default: begin e.mem_op = mem_lw; e.wb_sel = wb_memw; end
            endcase
        end
        op_store: if (f3 <= 3'd2) begin
            e.op1 = rs1v;
            e.op2 = im_s;
            e.mem_op = (f3 == 3'd0) ? mem_sb : (f3 == 3'd1) ? mem_sh : mem_sw;
        end
        op_op, op_op_imm: begin
            logic ok;
            ok = 1'b1;
            case (f3)
                3'd0: e.exe_fun = (w[5] && f7 == 7'h20) ? alu_sub : alu_add;
                3'd1: e.exe_fun = alu_sll;
                3'd2: e.exe_fun = alu_slt;
                3'd3: e.exe_fun = alu_sltu;
                3'd4: e.exe_fun = alu_xor;
                3'd5: e.exe_fun = (f7 == 7'h20) ? alu_sra : alu_srl;
                3'd6: e.exe_fun = alu_or;
                default: e.exe_fun = alu_and;
            endcase
            // funct7 only matters for register forms and for shifts
            if ((w[5] || f3 == 3'd1 || f3 == 3'd5) &&
                !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd5 || (w[5] && f3 == 3'd0)))))
                ok = 1'b0;
            if (ok) begin
                e.op1 = rs1v;
                e.op2 = w[5] ? regs[w[24:20]] : im_i;
                e.rf_wen = 1'b1;
                e.wb_sel = wb_alu;
            end else begin
                e.exe_fun = alu_add;
            end
        end
        op_branch: if (f3 != 3'd2 && f3 != 3'd3) begin
            e.exe_fun = (f3 == 3'd0) ? br_beq : (f3 == 3'd1) ? br_bne :
                        (f3 == 3'd4) ? br_blt : (f3 == 3'd5) ? br_bge :
                        (f3 == 3'd6) ? br_bltu : br_bgeu;
            e.op1 = rs1v;
            e.op2 = im_b;
        end
        op_jal: begin
            e.op1 = pc;
            e.op2 = im_j;
            e.rf_wen = 1'b1;
            e.wb_sel = wb_pc;
            e.jmp = 1'b1;
        end
        op_jalr: if (f3 == 3'd0) begin
            e.exe_fun = alu_jalr;
            e.op1 = rs1v;
            e.op2 = im_i;
            e.rf_wen = 1'b1;
            e.wb_sel = wb_pc;
            e.jmp = 1'b1;
        end
        op_lui, op_auipc: begin
            e.op1 = (w[5]) ? 32'd0 : pc;   // lui has no op1
            e.op2 = im_u;
            e.rf_wen = 1'b1;
            e.wb_sel = wb_alu;
        end
        default: ;
    endcase
    return e;
endfunction

`endif

//--- id_stage_tb.sv
module id_stage_tb
    import rv_isa_pkg::*;
    import ctrl_pkg::*;
;

    `include "id_ref.svh"

    localparam int n_inst = 200;

    logic clk, reset, mem_stall, flush;
    logic [31:0] in_inst, in_pc, rf_wdata;
    logic exe_rf_wen, mem_rf_wen, wb_rf_wen, rf_we;
    logic [4:0] exe_wb_addr, mem_wb_addr, wb_wb_addr, rf_waddr;
    logic [31:0] out_pc, op1_data, op2_data, rs2_data;
    logic [4:0] exe_fun, wb_addr;
    logic [3:0] mem_op, wb_sel;
    logic rf_wen, jmp_flg, hazard_stall;

    integer seed;
    int errors;
    logic [31:0] mirror [0:31];
    rv_inst_u held_inst;
    logic [31:0] held_pc;
    logic [31:0] next_word;
    logic [31:0] next_pc;
    exp_t cur;
    exp_t exp_q [$];

    tb_clock tb_clock_i (.clk(clk), .reset(reset));

    id_stage id_stage_i (.*);

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // random word from the instruction format table
    function automatic logic [31:0] random_inst();
        rv_inst_u w;
        logic [2:0] ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        w = $random(seed);
        if (rnd(6) == 0) w.r.rs1 = 5'd0;
        if (rnd(6) == 0) w.r.rs2 = 5'd0;
        case (rnd(10))
            0: begin
                w.r.opcode = op_op;
                w.r.funct7 = ((w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5) && rnd(2))
                             ? funct7_alt : 7'd0;
            end
            1: begin
                w.i.opcode = op_op_imm;
                if (w.i.funct3 == 3'd1) w.r.funct7 = 7'd0;
                if (w.i.funct3 == 3'd5) w.r.funct7 = rnd(2) ? funct7_alt : 7'd0;
            end
            2: begin
                w.i.opcode = op_load;
                w.i.funct3 = ld_f3[rnd(5)];
            end
            3: begin
                w.s.opcode = op_store;
                w.s.funct3 = 3'(rnd(3));
            end
            4: begin
                w.b.opcode = op_branch;
                w.b.funct3 = br_f3[rnd(6)];
            end
            5: w.j.opcode = op_jal;
            6: begin
                w.i.opcode = op_jalr;
                w.i.funct3 = 3'd0;
            end
            7: w.u.opcode = op_lui;
            8: w.u.opcode = op_auipc;
            default: w.r.opcode = 7'b1111111;   // no such opcode
        endcase
        return w;
    endfunction

    function automatic logic predict_hazard(input logic [4:0] rs1, input logic [4:0] rs2);
        logic [4:0] dst [3];
        logic en [3];
        dst = '{exe_wb_addr, mem_wb_addr, wb_wb_addr};
        en  = '{exe_rf_wen, mem_rf_wen, wb_rf_wen};
        for (int k = 0; k < 3; k++) begin
            if (en[k] && ((rs1 != 0 && dst[k] == rs1) || (rs2 != 0 && dst[k] == rs2)))
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_outputs(input exp_t e);
        check_field("out_pc", out_pc, e.pc);
        check_field("exe_fun", exe_fun, e.exe_fun);
        check_field("op1_data", op1_data, e.op1);
        check_field("op2_data", op2_data, e.op2);
        check_field("rs2_data", rs2_data, e.rs2);
        check_field("mem_op", mem_op, e.mem_op);
        check_field("rf_wen", rf_wen, e.rf_wen);
        check_field("wb_sel", wb_sel, e.wb_sel);
        check_field("wb_addr", wb_addr, e.wb_addr);
        check_field("jmp_flg", jmp_flg, e.jmp);
    endtask

    task automatic new_word();
        next_word = random_inst();
        next_pc   = next_pc + 32'd4;
    endtask

    // one cycle of stimulus on the falling edge
    task automatic step(input logic quiet, inout int issued);
        logic hz;
        mem_stall  = !quiet && rnd(8) == 0;
        flush      = !quiet && rnd(16) == 0;
        exe_rf_wen = !quiet && rnd(5) == 0;
        exe_wb_addr = 5'(rnd(32));
        if (!quiet && rnd(6) == 0) begin   // aim at a live source
            exe_rf_wen  = 1'b1;
            exe_wb_addr = held_inst.r.rs1;
        end
        mem_rf_wen  = !quiet && rnd(5) == 0;
        mem_wb_addr = 5'(rnd(32));
        wb_rf_wen   = !quiet && rnd(5) == 0;
        wb_wb_addr  = 5'(rnd(32));
        rf_we    = (rnd(2) != 0);
        rf_waddr = 5'(rnd(32));
        rf_wdata = $random(seed);
        in_inst  = quiet ? inst_nop : next_word;
        in_pc    = next_pc;
        hz = predict_hazard(held_inst.r.rs1, held_inst.r.rs2);
        #1;
        if (hazard_stall !== hz) begin
            errors++;
            $display("Error at %0t: hazard_stall is %b, expected %b", $time, hazard_stall, hz);
        end
        if (!mem_stall)
            cur = hz ? bubble_exp() : decode_ref(held_inst, held_pc, mirror);
        exp_q.push_back(cur);
        if (flush) begin
            held_inst = inst_nop;
            held_pc   = pc_nop;
        end else if (!mem_stall && !hz) begin
            held_inst = in_inst;
            held_pc   = in_pc;
        end
        if (!quiet && (flush || (!mem_stall && !hz))) begin
            issued++;
            new_word();
        end
        if (rf_we && rf_waddr != 5'd0) mirror[rf_waddr] = rf_wdata;
        @(negedge clk);
    endtask

    initial begin : drive
        int issued;
        issued = 0;
        errors = 0;
        seed = 32'h4820_7463;
        in_inst = inst_nop;
        in_pc = 32'd0;
        mem_stall = 1'b0;
        flush = 1'b0;
        {exe_rf_wen, mem_rf_wen, wb_rf_wen, rf_we} = '0;
        {exe_wb_addr, mem_wb_addr, wb_wb_addr, rf_waddr} = '0;
        rf_wdata = 32'd0;
        for (int r = 0; r < 32; r++) mirror[r] = 32'd0;
        held_inst = inst_nop;
        held_pc = pc_nop;
        cur = bubble_exp();
        next_pc = 32'h0000_0ffc;
        new_word();
        @(negedge reset);   // falls on the negedge after the last reset edge
        check_outputs(bubble_exp());   // idle after reset
        if (hazard_stall !== 1'b0) begin
            errors++;
            $display("Error at %0t: hazard_stall high after reset", $time);
        end
        while (issued < n_inst) step(1'b0, issued);
        repeat (4) step(1'b1, issued);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : compare
        exp_t e;
        forever begin
            @(posedge clk);
            #5;
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_outputs(e);
            end
        end
    end

    initial begin : watchdog
        #((n_inst * 40 + 8) * 20);
        $display("timeout: the run did not finish in time, errors: %0d", errors);
        $display("test failed");
        $finish;
    end

endmodule

//--- imm_gen.sv
module imm_gen
    import rv_isa_pkg::*;
(
    input  rv_inst_u        inst,
    output logic [xlen-1:0] imm_i,
    output logic [xlen-1:0] imm_s,
    output logic [xlen-1:0] imm_b,
    output logic [xlen-1:0] imm_j,
    output logic [xlen-1:0] imm_u
);

    assign imm_i = {{(xlen-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{(xlen-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};

    // bit 0 of branch and jump offsets is implied
    assign imm_b = {{(xlen-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                    inst.b.imm_4_1, 1'b0};
    assign imm_j = {{(xlen-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                    inst.j.imm_10_1, 1'b0};

    assign imm_u = {inst.u.imm_31_12, 12'd0};

endmodule

//--- inst_latch.sv
module inst_latch
    import rv_isa_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] in_inst,
    input  logic [xlen-1:0] in_pc,
    input  logic            mem_stall,
    input  logic            hazard_stall,
    input  logic            flush,
    output rv_inst_u        id_inst,
    output logic [xlen-1:0] id_pc
);

    // flush wins over both stalls
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            id_inst <= inst_nop;
            id_pc   <= pc_nop;
        end else if (!mem_stall && !hazard_stall) begin
            id_inst <= in_inst;
            id_pc   <= in_pc;
        end
    end

endmodule

//--- operand_stage.sv
module operand_stage
    import rv_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       id_pc,
    input  rv_inst_u              id_inst,
    input  logic [xlen-1:0]       rf_rs1_data,
    input  logic [xlen-1:0]       rf_rs2_data,
    input  logic [xlen-1:0]       imm_i,
    input  logic [xlen-1:0]       imm_s,
    input  logic [xlen-1:0]       imm_b,
    input  logic [xlen-1:0]       imm_j,
    input  logic [xlen-1:0]       imm_u,
    input  logic [alu_fn_w-1:0]   dec_exe_fun,
    input  logic [sel_w-1:0]      op1_sel,
    input  logic [sel_w-1:0]      op2_sel,
    input  logic [mem_op_w-1:0]   dec_mem_op,
    input  logic                  dec_rf_wen,
    input  logic [wb_sel_w-1:0]   dec_wb_sel,
    input  logic                  dec_jmp_flg,
    input  logic                  mem_stall,
    input  logic                  hazard_stall,
    output logic [xlen-1:0]       out_pc,
    output logic [alu_fn_w-1:0]   exe_fun,
    output logic [xlen-1:0]       op1_data,
    output logic [xlen-1:0]       op2_data,
    output logic [xlen-1:0]       rs2_data,
    output logic [mem_op_w-1:0]   mem_op,
    output logic                  rf_wen,
    output logic [wb_sel_w-1:0]   wb_sel,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic                  jmp_flg
);

    logic [xlen-1:0] op1_next;
    logic [xlen-1:0] op2_next;

    always_comb begin
        case (op1_sel)
            op1_rs1: op1_next = rf_rs1_data;
            op1_pc:  op1_next = id_pc;
            default: op1_next = '0;   // lui and unknown words
        endcase
        case (op2_sel)
            op2_rs2: op2_next = rf_rs2_data;
            op2_imi: op2_next = imm_i;
            op2_ims: op2_next = imm_s;
            op2_imb: op2_next = imm_b;
            op2_imj: op2_next = imm_j;
            op2_imu: op2_next = imm_u;
            default: op2_next = '0;
        endcase
    end

    // mem_stall freezes, hazard_stall inserts a bubble
    always_ff @(posedge clk) begin
        if (reset || (hazard_stall && !mem_stall)) begin
            out_pc   <= pc_nop;
            exe_fun  <= alu_add;
            op1_data <= '0;
            op2_data <= '0;
            rs2_data <= '0;
            mem_op   <= mem_none;
            rf_wen   <= 1'b0;
            wb_sel   <= wb_none;
            wb_addr  <= '0;
            jmp_flg  <= 1'b0;
        end else if (!mem_stall) begin
            out_pc   <= id_pc;
            exe_fun  <= dec_exe_fun;
            op1_data <= op1_next;
            op2_data <= op2_next;
            rs2_data <= rf_rs2_data;   // store data, branch compare
            mem_op   <= dec_mem_op;
            rf_wen   <= dec_rf_wen;
            wb_sel   <= dec_wb_sel;
            wb_addr  <= id_inst.r.rd;
            jmp_flg  <= dec_jmp_flg;
        end
    end

endmodule

//--- reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [1:31];   // no storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, the hazard stall covers pending writes
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // loads and stores
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    localparam logic [2:0] f3_add  = 3'b000;   // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;   // srl, sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] funct7_alt = 7'b0100000;   // sub / sra

    localparam logic [xlen-1:0] inst_nop = 32'h0000_0013;   // addi x0,x0,0
    localparam logic [xlen-1:0] pc_nop   = 32'h0000_0000;

    // one instruction word, seen in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

endpackage

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // period 20
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule
